// File: src/screen_pkg.sv
// Frame geometry, bus opcodes and FSM state types for the display streamer.
// Frame is kept tiny (4 lines of 16 bytes) so a simulated refresh stays short.
package screen_pkg;

  // frame geometry
  localparam int LINE_BYTES  = 16;   // pixel bytes per line
  localparam int FRAME_LINES = 4;    // lines per refresh

  // psram burst shape, counted in ram_clk periods
  localparam int RAM_ADDR_W = 24;
  localparam int CMD_CLKS   = 8;     // opcode, 1 bit per clock on io0
  localparam int ADDR_CLKS  = 6;     // 24 bit address, quad
  localparam int DUMMY_CLKS = 6;     // wait clocks before read data

  // derived widths
  localparam int LINE_IDX_W = $clog2(FRAME_LINES);       // row number
  localparam int LINE_CNT_W = $clog2(FRAME_LINES + 1);   // lines issued, 0..FRAME_LINES
  localparam int PIX_IDX_W  = $clog2(LINE_BYTES);        // byte slot inside one half
  localparam int NIB_CNT_W  = $clog2(2 * LINE_BYTES);    // nibbles per burst

  typedef enum logic [7:0] {
    RAM_QUAD_READ = 8'hEB            // fast quad read, 6 wait clocks
  } ram_op_e;

  typedef enum logic [7:0] {
    SCR_SET_ROW = 8'h2B,             // page/row address set
    SCR_WRITE   = 8'h2C              // memory write, pixels follow
  } scr_cmd_e;

  typedef enum logic [2:0] {
    R_IDLE,
    R_CMD,
    R_ADDR,
    R_DUMMY,
    R_DATA
  } reader_state_e;

  typedef enum logic [2:0] {
    W_IDLE,
    W_SET_ROW,
    W_ROW_ARG,
    W_WR_CMD,
    W_PIXELS
  } writer_state_e;

endpackage

// File: src/stream_if.sv
// Stage-to-stage links of the streamer pipeline. No handshake on either link.
// req is a 1-cycle strobe, allowed only while busy is low.
`timescale 1ns/1ps

interface line_req_if import screen_pkg::*; ();
  logic                  req;      // one line wanted
  logic [RAM_ADDR_W-1:0] addr;     // line index * LINE_BYTES
  logic [LINE_IDX_W-1:0] line;     // row number, travels with the bytes
  logic                  busy;     // reader burst in progress

  modport source (output req, output addr, output line, input busy);
  modport sink   (input req, input addr, input line, output busy);
endinterface

// byte stream never stalls, sender checks buffer space before it asks
interface byte_stream_if import screen_pkg::*; ();
  logic                  valid;    // one strobe per byte
  logic [7:0]            data;
  logic [LINE_IDX_W-1:0] line;
  logic                  last;     // final byte of the line

  modport source (output valid, output data, output line, output last);
  modport sink   (input valid, input data, input line, input last);
endinterface

// File: src/line_sequencer.sv
// Refresh on a btn[3] rising edge; btn is assumed already synchronous to clock.
// A refresh edge while a frame runs is dropped. Bank is fixed for the frame.
`timescale 1ns/1ps

module line_sequencer import screen_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic [3:0] btn,
  input  logic       buf_free,       // writer has a half to fill
  input  logic       buf_empty,      // writer has nothing left to send
  line_req_if.source req,
  output logic [1:0] ram_bank,
  output logic       frame_active
);

  logic                  btn3_q;     // previous btn[3], edge detect
  logic [LINE_CNT_W-1:0] issued;     // lines requested this frame
  logic                  refresh;
  logic                  all_issued;
  logic                  issue;
  logic                  drained;

  assign refresh    = btn[3] & ~btn3_q;
  assign all_issued = (issued == LINE_CNT_W'(FRAME_LINES));

  // req itself is checked since busy only rises the cycle after it
  assign issue = frame_active & ~all_issued & ~req.req & ~req.busy & buf_free;

  // frame over once the reader is quiet and both halves went out
  assign drained = all_issued & ~req.req & ~req.busy & buf_empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      btn3_q       <= 1'b0;
      frame_active <= 1'b0;
      issued       <= '0;
      ram_bank     <= 2'b00;
      req.req      <= 1'b0;
    end else begin
      btn3_q  <= btn[3];
      req.req <= issue;                    // registered strobe
      if (!frame_active) begin
        if (refresh) begin
          frame_active <= 1'b1;
          ram_bank     <= btn[1:0];        // bank held for the whole frame
          issued       <= '0;
        end
      end else if (issue) begin
        issued <= issued + 1'b1;
      end else if (drained) begin
        frame_active <= 1'b0;
      end
    end
  end

  // address and row ride along with the strobe
  always_ff @(posedge clock) begin
    if (issue) begin
      req.addr <= RAM_ADDR_W'(issued * LINE_BYTES);
      req.line <= issued[LINE_IDX_W-1:0];
    end
  end

endmodule

// File: src/qspi_ram_reader.sv
// Quad read (EB) burst per line request; PSRAM assumed already in SPI mode.
// ram_clk runs at clock/2, bits change on its fall, nibbles sampled on its rise.
`timescale 1ns/1ps

module qspi_ram_reader import screen_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  line_req_if.sink      req,
  byte_stream_if.source bytes,
  output logic          ram_csn,
  output logic          ram_clk,
  input  logic [3:0]    ram_io_in,
  output logic [3:0]    ram_io_out,
  output logic [3:0]    ram_io_oe
);

  reader_state_e         state;
  logic [RAM_ADDR_W-1:0] sh;          // opcode first, then address, msb out first
  logic [RAM_ADDR_W-1:0] addr_q;
  logic [LINE_IDX_W-1:0] line_q;
  logic [NIB_CNT_W-1:0]  cnt;         // periods per phase, nibbles in data
  logic [3:0]            nib_hi;      // high nibble waiting for its partner
  logic                  start;
  logic                  rise;        // this edge takes ram_clk high
  logic                  fall;        // this edge takes ram_clk low
  logic                  phase_end;

  assign start = (state == R_IDLE) & req.req;
  assign rise  = (state != R_IDLE) & ~ram_clk;
  assign fall  = (state != R_IDLE) & ram_clk;

  assign req.busy   = (state != R_IDLE);  // high from the cycle after req
  assign bytes.line = line_q;

  always_comb begin
    case (state)
      R_CMD:   phase_end = (cnt == NIB_CNT_W'(CMD_CLKS - 1));
      R_ADDR:  phase_end = (cnt == NIB_CNT_W'(ADDR_CLKS - 1));
      R_DUMMY: phase_end = (cnt == NIB_CNT_W'(DUMMY_CLKS - 1));
      default: phase_end = bytes.valid & bytes.last;  // last byte just went out
    endcase
  end

  // pin drive, single bit on io0 for the opcode
  always_comb begin
    ram_io_out = 4'h0;
    ram_io_oe  = 4'h0;
    case (state)
      R_CMD: begin
        ram_io_out = {3'b000, sh[RAM_ADDR_W-1]};
        ram_io_oe  = 4'b0001;
      end
      R_ADDR: begin
        ram_io_out = sh[RAM_ADDR_W-1 -: 4];
        ram_io_oe  = 4'b1111;
      end
      default: ;                          // dummy and data, pins released
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= R_IDLE;
      ram_csn     <= 1'b1;
      ram_clk     <= 1'b0;
      cnt         <= '0;
      bytes.valid <= 1'b0;
      bytes.last  <= 1'b0;
    end else begin
      bytes.valid <= 1'b0;
      bytes.last  <= 1'b0;
      if (start) begin
        state   <= R_CMD;
        ram_csn <= 1'b0;
        cnt     <= '0;
      end
      if (state != R_IDLE) ram_clk <= ~ram_clk;
      if (rise && state == R_DATA) begin
        cnt <= cnt + 1'b1;
        if (cnt[0]) begin                 // second nibble, byte complete
          bytes.valid <= 1'b1;
          bytes.last  <= (cnt == NIB_CNT_W'(2 * LINE_BYTES - 1));
        end
      end
      if (fall && phase_end) begin
        cnt <= '0;
        case (state)
          R_CMD:   state <= R_ADDR;
          R_ADDR:  state <= R_DUMMY;
          R_DUMMY: state <= R_DATA;
          default: begin
            state   <= R_IDLE;
            ram_csn <= 1'b1;              // ram_clk goes low on the same edge
          end
        endcase
      end else if (fall && state != R_DATA) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // shifter and byte assembly
  always_ff @(posedge clock) begin
    if (start) begin
      sh     <= {RAM_QUAD_READ, {(RAM_ADDR_W - 8){1'b0}}};
      addr_q <= req.addr;
      line_q <= req.line;
    end else if (fall && state == R_CMD) begin
      sh <= phase_end ? addr_q : {sh[RAM_ADDR_W-2:0], 1'b0};
    end else if (fall && state == R_ADDR) begin
      sh <= {sh[RAM_ADDR_W-5:0], 4'h0};
    end
    if (rise && state == R_DATA) begin
      if (!cnt[0]) nib_hi <= ram_io_in;  // high nibble comes first
      else bytes.data <= {nib_hi, ram_io_in};
    end
  end

endmodule

// File: src/screen_spi_writer.sv
// Two-line buffer in front of an SPI display, mode 0 at clock/2, MSB first.
// Per line: SET_ROW, row, WRITE with dc low, then LINE_BYTES pixels with dc high.
`timescale 1ns/1ps

module screen_spi_writer import screen_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  byte_stream_if.sink bytes,
  output logic        buf_free,
  output logic        buf_empty,
  output logic        screen_clk,
  output logic        screen_csn,
  output logic        screen_dc,
  output logic        screen_mosi,
  output logic        screen_resn
);

  logic [7:0]            mem [2*LINE_BYTES];  // half 0 then half 1
  logic [LINE_IDX_W-1:0] row [2];             // row number per half
  logic [1:0]            rdy;                 // half full, waiting or in flight
  logic                  wr_half;
  logic [PIX_IDX_W-1:0]  wr_idx;
  logic                  rd_half;
  logic [PIX_IDX_W-1:0]  px;                  // pixel now shifting
  logic [PIX_IDX_W-1:0]  px_nxt;
  writer_state_e         state;
  logic [7:0]            sh;
  logic [2:0]            bit_cnt;
  logic                  hold;                // stretches csn high to 2 clocks
  logic                  filling;
  logic                  start;
  logic                  byte_done;

  assign filling   = (wr_idx != '0);
  assign buf_free  = filling ? ~rdy[~wr_half] : ~(rdy[0] & rdy[1]);
  assign buf_empty = ~filling & ~rdy[0] & ~rdy[1];

  assign start     = (state == W_IDLE) & rdy[rd_half] & ~hold;
  assign byte_done = (state != W_IDLE) & screen_clk & (bit_cnt == 3'd7);
  assign px_nxt    = px + 1'b1;

  assign screen_mosi = ~screen_csn & sh[7];  // quiet low between lines

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= W_IDLE;
      screen_csn  <= 1'b1;
      screen_clk  <= 1'b0;
      screen_dc   <= 1'b0;
      screen_resn <= 1'b0;
      bit_cnt     <= '0;
      px          <= '0;
      rdy         <= 2'b00;
      wr_half     <= 1'b0;
      wr_idx      <= '0;
      rd_half     <= 1'b0;
      hold        <= 1'b0;
    end else begin
      screen_resn <= 1'b1;                // one clock after reset drops
      hold        <= 1'b0;
      if (bytes.valid) begin              // fill side, never stalls
        wr_idx <= wr_idx + 1'b1;          // wraps to 0 on the last byte
        if (bytes.last) begin
          rdy[wr_half] <= 1'b1;
          wr_half      <= ~wr_half;
        end
      end
      if (start) begin
        state      <= W_SET_ROW;
        screen_csn <= 1'b0;
        screen_dc  <= 1'b0;
        bit_cnt    <= '0;
      end
      if (state != W_IDLE) screen_clk <= ~screen_clk;
      if (state != W_IDLE && screen_clk) bit_cnt <= bit_cnt + 1'b1;
      if (byte_done) begin
        case (state)
          W_SET_ROW: state <= W_ROW_ARG;
          W_ROW_ARG: state <= W_WR_CMD;
          W_WR_CMD: begin
            state     <= W_PIXELS;
            screen_dc <= 1'b1;
            px        <= '0;
          end
          default: begin
            if (px == PIX_IDX_W'(LINE_BYTES - 1)) begin
              state        <= W_IDLE;
              screen_csn   <= 1'b1;
              screen_dc    <= 1'b0;
              rdy[rd_half] <= 1'b0;       // last bit is out, half is free
              rd_half      <= ~rd_half;
              hold         <= 1'b1;
            end else begin
              px <= px_nxt;
            end
          end
        endcase
      end
    end
  end

  // buffer writes and the output shifter
  always_ff @(posedge clock) begin
    if (bytes.valid) mem[{wr_half, wr_idx}] <= bytes.data;
    if (bytes.valid && bytes.last) row[wr_half] <= bytes.line;
    if (start) begin
      sh <= SCR_SET_ROW;
    end else if (byte_done) begin
      case (state)
        W_SET_ROW: sh <= {{(8 - LINE_IDX_W){1'b0}}, row[rd_half]};
        W_ROW_ARG: sh <= SCR_WRITE;
        W_WR_CMD:  sh <= mem[{rd_half, {PIX_IDX_W{1'b0}}}];
        default:   sh <= mem[{rd_half, px_nxt}];  // wraps harmlessly at line end
      endcase
    end else if (state != W_IDLE && screen_clk) begin
      sh <= {sh[6:0], 1'b0};
    end
  end

endmodule

// File: src/screen_stream_top.sv
// Streamer top: PSRAM line reads to an SPI display, two-line pipelined.
// Active-high sync reset; PSRAM data pins split into in, out and oe buses.
`timescale 1ns/1ps

module screen_stream_top (
  input  logic       clock,
  input  logic       reset,
  input  logic [3:0] btn,          // [3] refresh, [1:0] bank
  output logic [1:0] ram_bank,
  output logic       ram_csn,
  output logic       ram_clk,
  input  logic [3:0] ram_io_in,
  output logic [3:0] ram_io_out,
  output logic [3:0] ram_io_oe,
  output logic       screen_clk,
  output logic       screen_csn,
  output logic       screen_dc,
  output logic       screen_mosi,
  output logic       screen_resn,
  output logic       frame_active
);

  logic buf_free;
  logic buf_empty;

  line_req_if    req_if ();
  byte_stream_if byte_if ();

  line_sequencer seq0 (
    .clock        (clock),
    .reset        (reset),
    .btn          (btn),
    .buf_free     (buf_free),
    .buf_empty    (buf_empty),
    .req          (req_if.source),
    .ram_bank     (ram_bank),
    .frame_active (frame_active)
  );

  qspi_ram_reader rd0 (
    .clock      (clock),
    .reset      (reset),
    .req        (req_if.sink),
    .bytes      (byte_if.source),
    .ram_csn    (ram_csn),
    .ram_clk    (ram_clk),
    .ram_io_in  (ram_io_in),
    .ram_io_out (ram_io_out),
    .ram_io_oe  (ram_io_oe)
  );

  screen_spi_writer wr0 (
    .clock       (clock),
    .reset       (reset),
    .bytes       (byte_if.sink),
    .buf_free    (buf_free),
    .buf_empty   (buf_empty),
    .screen_clk  (screen_clk),
    .screen_csn  (screen_csn),
    .screen_dc   (screen_dc),
    .screen_mosi (screen_mosi),
    .screen_resn (screen_resn)
  );

endmodule

// File: tb/psram_model.sv
// Behavioral quad-SPI PSRAM, read only; knows just the EB quad read.
// Data is a fixed pattern of the address and bank; expects 4 bursts per frame.
`timescale 1ns/1ps

module psram_model import screen_pkg::*; (
  input  logic       ram_clk,
  input  logic       ram_csn,
  input  logic [3:0] io_out,         // driven by the DUT
  input  logic [3:0] io_oe,
  input  logic [1:0] bank,
  output logic [3:0] io_in,
  output int         errors
);

  int         rises = 0;             // ram_clk rises in this burst
  int         bursts = 0;
  int         err_cnt = 0;
  logic [7:0] op;
  logic [23:0] addr;
  logic [3:0] nib_q = 4'h0;          // nibble on the data pins

  assign errors = err_cnt;
  assign io_in  = nib_q;

  function automatic logic [7:0] pixel_of(input logic [1:0] b, input logic [23:0] a);
    return a[7:0] ^ {b, 6'b0};
  endfunction

  always @(posedge ram_clk or posedge ram_csn) begin
    if (ram_csn) begin
      if (rises != 0) begin          // burst just ended
        assert (op == RAM_QUAD_READ) else begin
          err_cnt++;
          $display("FAIL ram_io_out opcode exp %h got %h", RAM_QUAD_READ, op);
        end
        assert (addr == 24'((bursts % FRAME_LINES) * LINE_BYTES)) else begin
          err_cnt++;
          $display("FAIL ram_io_out address exp %h got %h",
                   24'((bursts % FRAME_LINES) * LINE_BYTES), addr);
        end
        assert ((rises - 20) == 2 * LINE_BYTES) else begin
          err_cnt++;
          $display("FAIL ram burst bytes exp %h got %h", LINE_BYTES, (rises - 20) / 2);
        end
        bursts++;
        rises = 0;
      end
    end else begin
      rises = rises + 1;
      if (rises <= 8) op = {op[6:0], io_out[0]};        // opcode on io0
      else if (rises <= 14) addr = {addr[19:0], io_out};  // quad address
      else begin
        assert (io_oe == 4'h0) else begin
          err_cnt++;
          $display("FAIL ram_io_oe exp %h got %h", 4'h0, io_oe);
        end
      end
    end
  end

  // data goes out on the fall after the last dummy clock
  always @(negedge ram_clk) begin
    int nib;
    logic [7:0] b;
    nib = rises - (8 + 6 + DUMMY_CLKS);
    if (nib >= 0 && nib < 2 * LINE_BYTES) begin
      b = pixel_of(bank, addr + 24'(nib / 2));
      nib_q <= nib[0] ? b[3:0] : b[7:4];  // high nibble first
    end
  end

endmodule

// File: tb/tb_top.sv
// Testbench for the display streamer: reset, three refreshes, SPI decode.
// Second refresh edge is pushed into one frame to check it is ignored.
`timescale 1ns/1ps

module tb_top import screen_pkg::*; ();

  localparam int LIMIT = 4 * 2000;   // cycle budget for 4 frames

  logic clock = 1'b0;
  logic reset;
  logic [3:0] btn;
  logic [1:0] ram_bank;
  logic ram_csn, ram_clk, screen_clk, screen_csn, screen_dc, screen_mosi;
  logic screen_resn, frame_active;
  logic [3:0] ram_io_in, ram_io_out, ram_io_oe, mdl_io;
  logic [1:0] exp_bank = 2'b00;
  int model_errors;
  int chk_errors = 0;                // stimulus side
  int mon_errors = 0;                // screen decode
  int sva_errors = 0;
  int total_lines = 0;
  int overlap_cycles = 0;
  int cycles = 0;
  int tests = 0;
  logic scl_q, csn_q;
  logic [7:0] rx;
  int nbits, nbytes;

  always #20 clock = ~clock;

  // per-pin io with the DUT winning where it drives
  assign ram_io_in = (ram_io_oe & ram_io_out) | (~ram_io_oe & mdl_io);

  screen_stream_top dut0 (.*);

  psram_model psram0 (.ram_clk(ram_clk), .ram_csn(ram_csn), .io_out(ram_io_out),
                      .io_oe(ram_io_oe), .bank(ram_bank), .io_in(mdl_io),
                      .errors(model_errors));

  function automatic logic [7:0] pixel_of(input logic [1:0] b, input int a);
    return a[7:0] ^ {b, 6'b0};
  endfunction

  function automatic int all_errors();
    return chk_errors + mon_errors + sva_errors + model_errors;
  endfunction

  bank_held: assert property (@(posedge clock) disable iff (reset)
                              frame_active |-> ram_bank == exp_bank)
    else begin
      sva_errors++;
      $display("FAIL ram_bank exp %h got %h", exp_bank, ram_bank);
    end

  // screen monitor on pre-edge values of the SPI pins
  always @(posedge clock) begin
    logic [7:0] exp;
    logic exp_dc;
    int row;
    if (reset) begin
      scl_q <= 1'b0;
      csn_q <= 1'b1;
    end else begin
      row = total_lines % FRAME_LINES;
      if (!ram_csn && !screen_csn) overlap_cycles++;
      if (!screen_csn && csn_q) begin  // window opens
        nbits = 0;
        nbytes = 0;
      end
      if (screen_csn && !csn_q) begin
        assert (nbytes == 3 + LINE_BYTES) else begin
          mon_errors++;
          $display("FAIL screen_csn window bytes exp %h got %h", 3 + LINE_BYTES, nbytes);
        end
        total_lines++;
      end
      if (!screen_csn && screen_clk && !scl_q) begin
        rx = {rx[6:0], screen_mosi};
        nbits++;
        if (nbits == 8) begin
          exp_dc = (nbytes >= 3);
          if (nbytes == 0) exp = SCR_SET_ROW;
          else if (nbytes == 1) exp = 8'(row);
          else if (nbytes == 2) exp = SCR_WRITE;
          else exp = pixel_of(exp_bank, row * LINE_BYTES + nbytes - 3);
          assert (rx == exp && screen_dc == exp_dc) else begin
            mon_errors++;
            $display("FAIL screen_mosi byte %0d exp %h got %h dc %h", nbytes, exp, rx,
                     screen_dc);
          end
          nbytes++;
          nbits = 0;
        end
      end
      scl_q <= screen_clk;
      csn_q <= screen_csn;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, a frame never finished", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // outputs that reset holds inactive, resn compared on its own
  task automatic check_idle(input logic resn_exp);
    assert (ram_csn && screen_csn && ram_io_oe == 4'h0 && !frame_active) else begin
      chk_errors++;
      $display("FAIL ram_csn screen_csn ram_io_oe frame_active exp 1 1 0 0 got %h %h %h %h",
               ram_csn, screen_csn, ram_io_oe, frame_active);
    end
    assert (screen_resn == resn_exp) else begin
      chk_errors++;
      $display("FAIL screen_resn exp %h got %h", resn_exp, screen_resn);
    end
  endtask

  task automatic run_frame(input logic [1:0] bank, input logic second_edge);
    int lines0, ov0, err0;
    lines0 = total_lines;
    ov0 = overlap_cycles;
    err0 = all_errors();
    @(posedge clock);
    #2 btn = {2'b10, bank};
    exp_bank = bank;
    @(posedge clock);
    #2 btn = 4'h0;
    assert (frame_active) else begin
      chk_errors++;
      $display("FAIL frame_active exp %h got %h", 1'b1, frame_active);
    end
    if (second_edge) begin
      repeat (150) @(posedge clock);
      #2 btn = {2'b10, ~bank};       // ignored while the frame runs
      repeat (2) @(posedge clock);
      #2 btn = 4'h0;
    end
    while (frame_active) @(posedge clock);
    assert (total_lines - lines0 == FRAME_LINES && screen_csn) else begin
      chk_errors++;
      $display("FAIL frame lines exp %h got %h", FRAME_LINES, total_lines - lines0);
    end
    assert (overlap_cycles > ov0) else begin
      chk_errors++;
      $display("no cycle had ram_csn and screen_csn low together in this frame");
    end
    tests++;
    $display("test frame bank %0d: %0d errors", bank, all_errors() - err0);
  endtask

  initial begin
    void'($urandom(32'h0223_d247));
    reset = 1'b1;
    btn = 4'h0;
    repeat (5) begin
      @(posedge clock);
      #2 check_idle(1'b0);
    end
    reset = 1'b0;
    @(posedge clock);
    #2 check_idle(1'b1);             // resn up one cycle after reset drops
    tests++;
    $display("test reset: %0d errors", chk_errors);
    for (int f = 0; f < 3; f++) begin
      repeat (1 + $urandom % 20) @(posedge clock);  // idle gap
      run_frame(2'($urandom % 4), f == 1);
    end
    $display("tests %0d, failed checks %0d", tests, all_errors());
    if (all_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
src/screen_pkg.sv
src/stream_if.sv
src/line_sequencer.sv
src/qspi_ram_reader.sv
src/screen_spi_writer.sv
src/screen_stream_top.sv
tb/psram_model.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
